/* vlog.f */
+incdir+verif
design/egress_pkg.sv
design/egress_port_demux.sv
design/egress_word_fifo.sv
design/egress_width_converter.sv
design/mpls_egress.sv
verif/mpls_egress_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass message

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mpls_egress_tb \
    -Mdir obj_dir -o mpls_egress_sim &&
./obj_dir/mpls_egress_sim > sim.log 2>&1 ||
echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* verif/egress_tb_tasks.svh */
// Egress testbench tasks
// Checks, packet stimulus, scoreboard and the directed tests

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        value_errors++;
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
endtask

task automatic report_failure(input string msg);
    other_errors++;
    $display("Failure: %s", msg);
endtask

task automatic print_error_counts();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
endtask

task automatic close_packet(input int port, input logic [3:0] keep);
    rx_len_q[port].push_back(rx_count[port]);
    rx_keep_q[port].push_back(keep);
    rx_count[port] = 0;
endtask

// Expected final lane keep holds length mod 4 bytes on a 32-bit port or a full lane
function automatic logic [3:0] last_keep_for(input int port, input int len);
    int rem;
    if (port < N8) begin
        return 4'h1;
    end
    rem = (len % 4 == 0) ? 4 : len % 4;
    return 4'((1 << rem) - 1);
endfunction

task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_ifc);
endtask

task automatic apply_reset();
    @(posedge clk_ifc);
    arst_n <= 1'b0;
    repeat (4) @(posedge clk_ifc);
    arst_n <= 1'b1;
    @(posedge clk_ifc);
endtask

task automatic clear_scoreboard();
    for (int p = 0; p < NP; p++) begin
        exp_len_q[p].delete();
        rx_len_q[p].delete();
        rx_keep_q[p].delete();
        rx_byte_q[p].delete();
    end
endtask

task automatic check_flags(input logic [N8-1:0] exp8, input logic [NP-N8-1:0] exp32);
    check_value("overflow8", 64'(overflow8), 64'(exp8));
    check_value("overflow32", 64'(overflow32), 64'(exp32));
endtask

// Beats are paced to the port rate and later beats carry a wrong port number
task automatic send_packet(input int port, input int len, input bit expect_rx);
    int                   nwords;
    int                   gap;
    int                   idx;
    egress_pkg::in_word_t word;
    egress_pkg::in_keep_t keep;
    nwords = (len + 7) / 8;
    gap    = (port < N8) ? 7 : 1;
    for (int w = 0; w < nwords; w++) begin
        for (int k = 0; k < 8; k++) begin
            idx           = w * 8 + k;
            keep[k]       = idx < len;
            word[8*k +: 8] = (idx < len) ? 8'(idx % 256) : 8'hee;
        end
        @(posedge clk_ifc);
        in_valid <= 1'b1;
        in_data  <= word;
        in_keep  <= keep;
        in_last  <= w == nwords - 1;
        in_port  <= (w == 0) ? egress_pkg::port_idx_t'(port) : ~egress_pkg::port_idx_t'(port);
        @(posedge clk_ifc);
        in_valid <= 1'b0;
        repeat (gap - 1) @(posedge clk_ifc);
    end
    if (expect_rx) begin
        exp_len_q[port].push_back(len);
    end
endtask

task automatic wait_for_packets();
    logic done;
    logic extra;
    done  = 1'b0;
    extra = 1'b0;
    while (!done && !extra) begin
        @(posedge clk_ifc);
        done = 1'b1;
        for (int p = 0; p < NP; p++) begin
            if (rx_len_q[p].size() < exp_len_q[p].size()) begin
                done = 1'b0;
            end
            if (rx_len_q[p].size() > exp_len_q[p].size()) begin
                extra = 1'b1;
                report_failure($sformatf("port %0d showed a packet not sent to it", p));
            end
        end
    end
endtask

task automatic verify_port(input int port);
    int         len;
    int         rx_len;
    logic [3:0] keep;
    logic [7:0] data;
    while (exp_len_q[port].size() > 0) begin
        len = exp_len_q[port].pop_front();
        if (rx_len_q[port].size() == 0) begin
            report_failure($sformatf("port %0d never delivered a %0d-byte packet", port, len));
        end else begin
            rx_len = rx_len_q[port].pop_front();
            keep   = rx_keep_q[port].pop_front();
            check_value($sformatf("port %0d length", port), 64'(rx_len), 64'(len));
            check_value($sformatf("port %0d last keep", port), 64'(keep),
                        64'(last_keep_for(port, len)));
            for (int b = 0; b < rx_len; b++) begin
                data = rx_byte_q[port].pop_front();
                check_value($sformatf("port %0d byte %0d", port, b), 64'(data), 64'(b % 256));
            end
        end
    end
    if (rx_len_q[port].size() != 0) begin
        report_failure($sformatf("port %0d delivered packets that were not sent", port));
    end
endtask

task automatic verify_all_ports();
    for (int p = 0; p < NP; p++) begin
        verify_port(p);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic route_to_all_ports();
    int len;
    for (int n = 0; n < 30; n++) begin
        len = 1 + int'($unsigned($random(seed)) % 256);
        send_packet(n % NP, len, 1'b1);
    end
    wait_for_packets();
    verify_all_ports();
endtask

task automatic send_edge_lengths();
    int lengths [6] = '{1, 3, 4, 8, 9, 63};
    for (int i = 0; i < 6; i++) begin
        send_packet(1, lengths[i], 1'b1);
        send_packet(4, lengths[i], 1'b1);
    end
    wait_for_packets();
    verify_all_ports();
endtask

task automatic stress_back_pressure();
    random_ready <= 1'b1;
    for (int n = 0; n < 12; n++) begin
        send_packet(n % NP, 12, 1'b1);
        idle_cycles(16);
    end
    wait_for_packets();
    random_ready <= 1'b0;
    verify_all_ports();
    check_flags('0, '0);
endtask

// Port 4 is bit 1 of the 32-bit group
task automatic force_overflow();
    ready32_set <= 3'b101;
    idle_cycles(2);
    send_packet(4, 200, 1'b0);
    idle_cycles(4);
    check_flags('0, 3'b010);
    send_packet(0, 50, 1'b1);
    wait_for_packets();
    verify_port(0);
    check_flags('0, 3'b010);
    apply_reset();
    ready32_set <= '1;
    clear_scoreboard();
    check_flags('0, '0);
endtask

// Long enough that beats steered to an 8-bit port would overflow its buffer
task automatic drop_bad_port();
    idle_cycles(2);
    valid_cycles = 0;
    send_packet(6, 200, 1'b0);
    send_packet(7, 200, 1'b0);
    // Well past the three-cycle path from input to lane
    idle_cycles(20);
    check_value("valid cycles", 64'(valid_cycles), 64'h0);
    check_flags('0, '0);
    send_packet(2, 33, 1'b1);
    wait_for_packets();
    verify_all_ports();
endtask

/* verif/mpls_egress_tb.sv */
// MPLS egress testbench
// Sends incrementing-byte packets into the egress stage and checks every physical port

`timescale 1ns/100ps

module mpls_egress_tb;

    localparam int NP = egress_pkg::NUM_PORTS;
    localparam int N8 = egress_pkg::NUM_8B_PORTS;

    // Covers about 150 packets of up to 256 bytes paced near port rate
    localparam int CYCLE_LIMIT = 40000;

    logic                  clk_ifc;
    logic                  arst_n;
    logic                  in_valid;
    egress_pkg::in_word_t  in_data;
    egress_pkg::in_keep_t  in_keep;
    logic                  in_last;
    egress_pkg::port_idx_t in_port;

    logic [N8-1:0]                     out8_valid;
    egress_pkg::lane8_t [N8-1:0]       out8_data;
    logic [N8-1:0]                     out8_keep;
    logic [N8-1:0]                     out8_last;
    logic [N8-1:0]                     out8_ready;
    logic [NP-N8-1:0]                  out32_valid;
    egress_pkg::lane32_t [NP-N8-1:0]   out32_data;
    logic [NP-N8-1:0][3:0]             out32_keep;
    logic [NP-N8-1:0]                  out32_last;
    logic [NP-N8-1:0]                  out32_ready;
    logic [N8-1:0]                     overflow8;
    logic [NP-N8-1:0]                  overflow32;

    // Scoreboard queues per port
    int         exp_len_q [NP][$];
    int         rx_len_q  [NP][$];
    logic [3:0] rx_keep_q [NP][$];
    logic [7:0] rx_byte_q [NP][$];
    int         rx_count  [NP];
    int         valid_cycles;

    int value_errors = 0;
    int other_errors = 0;
    int cycle_count;
    int seed = 32'h0cf030d8;

    // Random ready mode and the fixed ready of the 32-bit ports
    logic             random_ready = 1'b0;
    logic [NP-N8-1:0] ready32_set  = '1;

    mpls_egress dut_i (
        .clk_ifc     (clk_ifc),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_keep     (in_keep),
        .in_last     (in_last),
        .in_port     (in_port),
        .out8_valid  (out8_valid),
        .out8_data   (out8_data),
        .out8_keep   (out8_keep),
        .out8_last   (out8_last),
        .out8_ready  (out8_ready),
        .out32_valid (out32_valid),
        .out32_data  (out32_data),
        .out32_keep  (out32_keep),
        .out32_last  (out32_last),
        .out32_ready (out32_ready),
        .overflow8   (overflow8),
        .overflow32  (overflow32)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #5 clk_ifc = ~clk_ifc;
    end

    `include "egress_tb_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Ready driver that never holds a port low for more than 8 cycles in random mode

    initial begin : drive_ready
        int            stall [NP];
        int            r;
        logic [NP-1:0] rdy;
        out8_ready  = '0;
        out32_ready = '0;
        stall       = '{default: 0};
        forever begin
            @(posedge clk_ifc);
            if (random_ready) begin
                for (int p = 0; p < NP; p++) begin
                    r        = $random(seed);
                    rdy[p]   = stall[p] >= 8 || r[12];
                    stall[p] = rdy[p] ? 0 : stall[p] + 1;
                end
            end else begin
                rdy   = {ready32_set, {N8{1'b1}}};
                stall = '{default: 0};
            end
            out8_ready  <= rdy[N8-1:0];
            out32_ready <= rdy[NP-1:N8];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port monitors

    always @(posedge clk_ifc) begin : collect_lanes
        int p;
        if (!arst_n) begin
            rx_count = '{default: 0};
        end else begin
            if ((|out8_valid) || (|out32_valid)) begin
                valid_cycles++;
            end
            for (int i = 0; i < N8; i++) begin
                if (out8_valid[i] && out8_ready[i]) begin
                    if (out8_keep[i]) begin
                        rx_byte_q[i].push_back(out8_data[i]);
                        rx_count[i]++;
                    end
                    if (out8_last[i]) begin
                        close_packet(i, 4'(out8_keep[i]));
                    end else begin
                        check_value($sformatf("out8_keep[%0d]", i), 64'(out8_keep[i]), 64'h1);
                    end
                end
            end
            for (int i = 0; i < NP - N8; i++) begin
                p = N8 + i;
                if (out32_valid[i] && out32_ready[i]) begin
                    for (int k = 0; k < 4; k++) begin
                        if (out32_keep[i][k]) begin
                            rx_byte_q[p].push_back(out32_data[i][8*k +: 8]);
                            rx_count[p]++;
                        end
                    end
                    if (out32_last[i]) begin
                        close_packet(p, out32_keep[i]);
                    end else begin
                        check_value($sformatf("out32_keep[%0d]", i), 64'(out32_keep[i]), 64'hf);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_ifc);
            cycle_count++;
        end
        report_failure($sformatf("timeout, run stopped after %0d cycles", CYCLE_LIMIT));
        print_error_counts();
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_sequence
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_keep  = '0;
        in_last  = 1'b0;
        in_port  = '0;
        apply_reset();
        route_to_all_ports();
        send_edge_lengths();
        stress_back_pressure();
        force_overflow();
        drop_bad_port();
        @(posedge clk_ifc);
        print_error_counts();
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* design/mpls_egress.sv */
// MPLS egress stage
// Steers the 64-bit packet stream to three 8-bit and three 32-bit physical ports

`timescale 1ns/100ps

module mpls_egress (
    input  logic                                         clk_ifc,
    input  logic                                         arst_n,
    // Packet stream from the packet processor
    input  logic                                         in_valid,
    input  egress_pkg::in_word_t                         in_data,
    input  egress_pkg::in_keep_t                         in_keep,
    input  logic                                         in_last,
    input  egress_pkg::port_idx_t                        in_port,
    // 8-bit ports, indices 0 to 2
    output logic [egress_pkg::NUM_8B_PORTS-1:0]          out8_valid,
    output egress_pkg::lane8_t [egress_pkg::NUM_8B_PORTS-1:0] out8_data,
    output logic [egress_pkg::NUM_8B_PORTS-1:0]          out8_keep,
    output logic [egress_pkg::NUM_8B_PORTS-1:0]          out8_last,
    input  logic [egress_pkg::NUM_8B_PORTS-1:0]          out8_ready,
    // 32-bit ports, indices 3 to 5
    output logic [egress_pkg::NUM_32B_PORTS-1:0]         out32_valid,
    output egress_pkg::lane32_t [egress_pkg::NUM_32B_PORTS-1:0] out32_data,
    output logic [egress_pkg::NUM_32B_PORTS-1:0][3:0]    out32_keep,
    output logic [egress_pkg::NUM_32B_PORTS-1:0]         out32_last,
    input  logic [egress_pkg::NUM_32B_PORTS-1:0]         out32_ready,
    // Sticky buffer overflow flags
    output logic [egress_pkg::NUM_8B_PORTS-1:0]          overflow8,
    output logic [egress_pkg::NUM_32B_PORTS-1:0]         overflow32
);

    // Demux to buffers
    logic [egress_pkg::NUM_PORTS-1:0] word_wr;
    egress_pkg::in_word_t             word_data;
    egress_pkg::in_keep_t             word_keep;
    logic                             word_last;

    // Buffers to converters, one entry per port
    logic [egress_pkg::NUM_PORTS-1:0] buf_valid;
    egress_pkg::in_word_t             buf_data [egress_pkg::NUM_PORTS];
    egress_pkg::in_keep_t             buf_keep [egress_pkg::NUM_PORTS];
    logic [egress_pkg::NUM_PORTS-1:0] buf_last;
    logic [egress_pkg::NUM_PORTS-1:0] buf_pop;
    logic [egress_pkg::NUM_PORTS-1:0] overflow;

    egress_port_demux demux_i (
        .clk_ifc   (clk_ifc),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_port   (in_port),
        .word_wr   (word_wr),
        .word_data (word_data),
        .word_keep (word_keep),
        .word_last (word_last)
    );

    for (genvar p = 0; p < egress_pkg::NUM_PORTS; p++) begin : g_fifo
        egress_word_fifo fifo_i (
            .clk_ifc  (clk_ifc),
            .arst_n   (arst_n),
            .wr       (word_wr[p]),
            .wr_data  (word_data),
            .wr_keep  (word_keep),
            .wr_last  (word_last),
            .rd_valid (buf_valid[p]),
            .rd_data  (buf_data[p]),
            .rd_keep  (buf_keep[p]),
            .rd_last  (buf_last[p]),
            .pop      (buf_pop[p]),
            .overflow (overflow[p])
        );
    end

    // Port numbering puts the 8-bit group first
    for (genvar i = 0; i < egress_pkg::NUM_8B_PORTS; i++) begin : g_conv8
        egress_width_converter #(.OUT_BYTES(1)) conv_i (
            .clk_ifc (clk_ifc), .arst_n (arst_n),
            .buf_valid (buf_valid[i]), .buf_data (buf_data[i]),
            .buf_keep (buf_keep[i]), .buf_last (buf_last[i]), .buf_pop (buf_pop[i]),
            .out_valid (out8_valid[i]), .out_data (out8_data[i]),
            .out_keep (out8_keep[i]), .out_ready (out8_ready[i]), .out_last (out8_last[i])
        );
    end

    for (genvar i = 0; i < egress_pkg::NUM_32B_PORTS; i++) begin : g_conv32
        localparam int P = egress_pkg::NUM_8B_PORTS + i;
        egress_width_converter #(.OUT_BYTES(4)) conv_i (
            .clk_ifc (clk_ifc), .arst_n (arst_n),
            .buf_valid (buf_valid[P]), .buf_data (buf_data[P]),
            .buf_keep (buf_keep[P]), .buf_last (buf_last[P]), .buf_pop (buf_pop[P]),
            .out_valid (out32_valid[i]), .out_data (out32_data[i]),
            .out_keep (out32_keep[i]), .out_ready (out32_ready[i]), .out_last (out32_last[i])
        );
    end

    assign overflow8  = overflow[egress_pkg::NUM_8B_PORTS-1:0];
    assign overflow32 = overflow[egress_pkg::NUM_PORTS-1:egress_pkg::NUM_8B_PORTS];

endmodule

/* design/egress_width_converter.sv */
// Egress width converter
// Splits buffered 64-bit words into lanes of OUT_BYTES, trimming the final word by its keep mask

`timescale 1ns/100ps

module egress_width_converter #(
    parameter int OUT_BYTES = 4
) (
    input  logic                   clk_ifc,
    input  logic                   arst_n,
    input  logic                   buf_valid,
    input  egress_pkg::in_word_t   buf_data,
    input  egress_pkg::in_keep_t   buf_keep,
    input  logic                   buf_last,
    output logic                   buf_pop,
    output logic                   out_valid,
    output logic [OUT_BYTES*8-1:0] out_data,
    output logic [OUT_BYTES-1:0]   out_keep,
    input  logic                   out_ready,
    output logic                   out_last
);

    egress_pkg::conv_state_t state;

    // Word being sent, the lowest remaining lane is always at the bottom
    egress_pkg::in_word_t data_sr;

    // Keep bits shift along with the data, so the word ends when nothing is kept above this lane
    egress_pkg::in_keep_t keep_sr;
    logic                 last_q;

    logic lane_final;
    logic lane_xfer;
    logic take;

    ////////////////////////////////////////////////////////////////////////////
    // Lane bookkeeping

    // No kept bytes past the current lane, this is the word's last lane
    assign lane_final = (keep_sr >> OUT_BYTES) == '0;

    assign lane_xfer = out_valid && out_ready;

    // Fetch the next word when idle or while the final lane leaves
    assign take    = buf_valid && (state == egress_pkg::CONV_IDLE || (lane_xfer && lane_final));
    assign buf_pop = take;

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state <= egress_pkg::CONV_IDLE;
        end else begin
            case (state)
                egress_pkg::CONV_IDLE: begin
                    if (take) begin
                        state <= egress_pkg::CONV_SEND;
                    end
                end
                egress_pkg::CONV_SEND: begin
                    // Stay in SEND when the next word is fetched back to back
                    if (lane_xfer && lane_final && !take) begin
                        state <= egress_pkg::CONV_IDLE;
                    end
                end
                default: state <= egress_pkg::CONV_IDLE;
            endcase
        end
    end

    // Word register and lane shifter
    always_ff @(posedge clk_ifc) begin
        if (take) begin
            data_sr <= buf_data;
            keep_sr <= buf_keep;
            last_q  <= buf_last;
        end else if (lane_xfer) begin
            data_sr <= data_sr >> (OUT_BYTES * 8);
            keep_sr <= keep_sr >> OUT_BYTES;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lane outputs

    assign out_valid = state == egress_pkg::CONV_SEND;
    assign out_data  = data_sr[OUT_BYTES*8-1:0];

    // Full on every lane but the packet's last, which is partial when the length says so
    assign out_keep  = keep_sr[OUT_BYTES-1:0];
    assign out_last  = out_valid && last_q && lane_final;

    // A stalled lane holds until the sink accepts it
    assert property (@(posedge clk_ifc) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("width_converter: lane changed while stalled");

endmodule

/* design/egress_word_fifo.sv */
// Egress word buffer
// Circular buffer of input words per port, drops writes when full and flags it

`timescale 1ns/100ps

module egress_word_fifo (
    input  logic                 clk_ifc,
    input  logic                 arst_n,
    input  logic                 wr,
    input  egress_pkg::in_word_t wr_data,
    input  egress_pkg::in_keep_t wr_keep,
    input  logic                 wr_last,
    output logic                 rd_valid,
    output egress_pkg::in_word_t rd_data,
    output egress_pkg::in_keep_t rd_keep,
    output logic                 rd_last,
    input  logic                 pop,
    output logic                 overflow
);

    // Storage
    egress_pkg::in_word_t data_mem [egress_pkg::FIFO_DEPTH];
    egress_pkg::in_keep_t keep_mem [egress_pkg::FIFO_DEPTH];
    logic                 last_mem [egress_pkg::FIFO_DEPTH];

    egress_pkg::fifo_ptr_t wr_ptr;
    egress_pkg::fifo_ptr_t rd_ptr;

    // One bit wider than the pointers so that a full buffer is distinct from empty
    logic [egress_pkg::FIFO_PTR_BITS:0] count;

    logic full;
    logic wr_en;

    assign full  = count == egress_pkg::FIFO_DEPTH;
    assign wr_en = wr && !full;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, fill level and overflow flag

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until the next reset
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= wr_data;
            keep_mem[wr_ptr] <= wr_keep;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    // Head word, visible the cycle after it was written
    assign rd_valid = count != '0;
    assign rd_data  = data_mem[rd_ptr];
    assign rd_keep  = keep_mem[rd_ptr];
    assign rd_last  = last_mem[rd_ptr];

    // The converter only takes a word that is there
    assert property (@(posedge clk_ifc) disable iff (!arst_n)
        pop |-> rd_valid)
        else $error("word_fifo: pop while empty");

endmodule

/* design/egress_port_demux.sv */
// Egress port demux
// Latches the port number of each packet and steers its words to that port's buffer

`timescale 1ns/100ps

module egress_port_demux (
    input  logic                          clk_ifc,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  egress_pkg::in_word_t          in_data,
    input  egress_pkg::in_keep_t          in_keep,
    input  logic                          in_last,
    input  egress_pkg::port_idx_t         in_port,
    output logic [egress_pkg::NUM_PORTS-1:0] word_wr,
    output egress_pkg::in_word_t          word_data,
    output egress_pkg::in_keep_t          word_keep,
    output logic                          word_last
);

    // High when the next valid beat opens a packet
    logic                  sop;
    egress_pkg::port_idx_t port_q;
    egress_pkg::port_idx_t cur_port;
    logic                  port_ok;

    // First beat uses in_port directly, the rest of the packet the latched copy
    assign cur_port = sop ? in_port : port_q;

    // Port numbers past the last physical port drop the whole packet
    assign port_ok = cur_port < egress_pkg::NUM_PORTS;

    ////////////////////////////////////////////////////////////////////////////
    // Packet tracking and write strobes

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            sop     <= 1'b1;
            port_q  <= '0;
            word_wr <= '0;
        end else begin
            word_wr <= '0;
            if (in_valid) begin
                sop <= in_last;
                if (sop) begin
                    port_q <= in_port;
                end
                if (port_ok) begin
                    word_wr[cur_port] <= 1'b1;
                end
            end
        end
    end

    // Word payload shared by all buffers
    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            word_data <= in_data;
            word_keep <= in_keep;
            word_last <= in_last;
        end
    end

    // Closing beat must carry at least one byte, the converters rely on it
    assert property (@(posedge clk_ifc) disable iff (!arst_n)
        in_valid && in_last |-> in_keep != '0)
        else $error("demux: in_last beat with empty in_keep");

endmodule

/* design/egress_pkg.sv */
// Egress package
// Constants and types shared by the port demux, the word buffers and the width converters

package egress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // Input stream word in bytes
    localparam int IN_BYTES = 8;

    // Physical port groups, 8-bit ports come first in the port numbering
    localparam int NUM_8B_PORTS  = 3;
    localparam int NUM_32B_PORTS = 3;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS;
    localparam int PORT_IDX_BITS = $clog2(NUM_PORTS);

    // Per-port word buffer
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // Input word, byte 0 of the packet sits in bits 7:0
    typedef logic [IN_BYTES*8-1:0] in_word_t;

    // Byte-valid mask, bit i covers bits 8i+7 down to 8i
    typedef logic [IN_BYTES-1:0]   in_keep_t;

    typedef logic [PORT_IDX_BITS-1:0] port_idx_t;
    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;

    // Lanes of the physical ports
    typedef logic [7:0]  lane8_t;
    typedef logic [31:0] lane32_t;

    // Width converter states
    typedef enum logic {
        CONV_IDLE,
        CONV_SEND
    } conv_state_t;

endpackage
